//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

	// datapath and register file shape
	localparam int WORD_BITS   = 16;	// data and address width
	localparam int REG_BITS    = 4;
	localparam int NUM_REGS    = 16;
	localparam int IMM_HI_BITS = 12;	// upper immediate loaded by the prefix
	localparam int FN_BITS     = 4;
	localparam int SHAMT_BITS  = 4;	// shift amount comes from the low bits of operand b

	// two-operand functions, a is the destination value
	localparam logic [FN_BITS-1:0] FN_MOV = 4'd0;
	localparam logic [FN_BITS-1:0] FN_ADD = 4'd1;
	localparam logic [FN_BITS-1:0] FN_SUB = 4'd2;
	localparam logic [FN_BITS-1:0] FN_AND = 4'd3;
	localparam logic [FN_BITS-1:0] FN_OR  = 4'd4;
	localparam logic [FN_BITS-1:0] FN_XOR = 4'd5;
	localparam logic [FN_BITS-1:0] FN_SHL = 4'd6;
	localparam logic [FN_BITS-1:0] FN_SHR = 4'd7;

	// single-operand functions, only a is looked at
	localparam logic [FN_BITS-1:0] FN_NOT = 4'd8;
	localparam logic [FN_BITS-1:0] FN_NEG = 4'd9;
	localparam logic [FN_BITS-1:0] FN_INC = 4'd10;
	localparam logic [FN_BITS-1:0] FN_DEC = 4'd11;

	// codes 12..15 are unassigned, the ALU passes a through with carry clear

endpackage

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int OP_BITS     = 4;
	localparam int COND_BITS   = 3;
	localparam int IMM_LO_BITS = core_pkg::WORD_BITS - core_pkg::IMM_HI_BITS;

	// major opcodes, bits 15:12
	localparam logic [OP_BITS-1:0] OP_NOP    = 4'h0;
	localparam logic [OP_BITS-1:0] OP_PREFIX = 4'h1;
	localparam logic [OP_BITS-1:0] OP_ALU_RR = 4'h2;
	localparam logic [OP_BITS-1:0] OP_ALU_RI = 4'h3;
	localparam logic [OP_BITS-1:0] OP_BRANCH = 4'h4;

	// minor opcodes in bits 11:8 under OP_NOP
	localparam logic [core_pkg::FN_BITS-1:0] SUB_INC   = 4'h2;
	localparam logic [core_pkg::FN_BITS-1:0] SUB_DEC   = 4'h3;
	localparam logic [core_pkg::FN_BITS-1:0] SUB_UNARY = 4'h4;	// fn code in bits 7:4

	// branch conditions, code 7 is never taken
	localparam logic [COND_BITS-1:0] COND_Z      = 3'd0;
	localparam logic [COND_BITS-1:0] COND_NZ     = 3'd1;
	localparam logic [COND_BITS-1:0] COND_S      = 3'd2;
	localparam logic [COND_BITS-1:0] COND_NS     = 3'd3;
	localparam logic [COND_BITS-1:0] COND_C      = 3'd4;
	localparam logic [COND_BITS-1:0] COND_NC     = 3'd5;
	localparam logic [COND_BITS-1:0] COND_ALWAYS = 3'd6;

	typedef union packed {
		logic [core_pkg::WORD_BITS-1:0] word;
		struct packed {
			logic [OP_BITS-1:0]            major;
			logic [core_pkg::FN_BITS-1:0]  fn;
			logic [core_pkg::REG_BITS-1:0] rd;
			logic [core_pkg::REG_BITS-1:0] rs;
		} alu_view;
		struct packed {
			logic [OP_BITS-1:0]     major;
			logic                   rsvd;
			logic [COND_BITS-1:0]   cond;
			logic [3:0]             rsvd_nib;
			logic [IMM_LO_BITS-1:0] target_lo;
		} branch_view;
		struct packed {
			logic [OP_BITS-1:0]               major;
			logic [core_pkg::IMM_HI_BITS-1:0] imm_hi;
		} prefix_view;
	} instr_u;

	localparam instr_u NOP_WORD = '0;

endpackage

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [core_pkg::FN_BITS-1:0]    fn,
	input  logic [core_pkg::WORD_BITS-1:0]  a,
	input  logic [core_pkg::WORD_BITS-1:0]  b,
	output logic [core_pkg::WORD_BITS-1:0]  result,
	output logic                            carry
);
	import core_pkg::*;

	logic [WORD_BITS:0]    wide;	// carry or borrow lands in the top bit
	logic [WORD_BITS:0]    shr_tmp;
	logic [SHAMT_BITS-1:0] shamt;

	assign shamt   = b[SHAMT_BITS-1:0];
	assign shr_tmp = {a, 1'b0} >> shamt;	// bit 0 ends up as the last bit shifted out

	always_comb begin
		case (fn)
			FN_MOV:  wide = {1'b0, b};
			FN_ADD:  wide = {1'b0, a} + {1'b0, b};
			FN_SUB:  wide = {1'b0, a} - {1'b0, b};
			FN_AND:  wide = {1'b0, a & b};
			FN_OR:   wide = {1'b0, a | b};
			FN_XOR:  wide = {1'b0, a ^ b};
			FN_SHL:  wide = {1'b0, a} << shamt;
			FN_SHR:  wide = {shr_tmp[0], shr_tmp[WORD_BITS:1]};
			FN_NOT:  wide = {1'b0, ~a};
			FN_NEG:  wide = '0 - {1'b0, a};	// borrow set for any nonzero a
			FN_INC:  wide = {1'b0, a} + 1'b1;
			FN_DEC:  wide = {1'b0, a} - 1'b1;
			default: wide = {1'b0, a};
		endcase
	end

	assign result = wide[WORD_BITS-1:0];
	assign carry  = wide[WORD_BITS];

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  logic                            wr_en,
	input  logic [core_pkg::REG_BITS-1:0]   wr_addr,
	input  logic [core_pkg::WORD_BITS-1:0]  wr_data,
	input  logic [core_pkg::REG_BITS-1:0]   rd_addr_a,
	input  logic [core_pkg::REG_BITS-1:0]   rd_addr_b,
	output logic [core_pkg::WORD_BITS-1:0]  rd_data_a,
	output logic [core_pkg::WORD_BITS-1:0]  rd_data_b
);
	import core_pkg::*;

	logic [WORD_BITS-1:0] regs [NUM_REGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;	// architectural state starts at zero
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// same-cycle write is forwarded to the readers
	assign rd_data_a = (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  logic [core_pkg::WORD_BITS-1:0]  imem_data,
	input  logic                            stall,
	input  logic                            branch_taken,
	input  logic [core_pkg::WORD_BITS-1:0]  branch_target,
	output logic [core_pkg::WORD_BITS-1:0]  imem_addr,
	output isa_pkg::instr_u                 instr
);
	import core_pkg::*;
	import isa_pkg::*;

	logic [WORD_BITS-1:0] pc;

	assign imem_addr = pc;	// memory answers in the same cycle

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc    <= '0;
			instr <= NOP_WORD;
		end else if (branch_taken) begin
			// the word fetched this cycle is on the wrong path
			pc    <= branch_target;
			instr <= NOP_WORD;
		end else if (!stall) begin
			pc         <= pc + 1'b1;
			instr.word <= imem_data;
		end
		// on a stall both pc and instr keep their value
	end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  isa_pkg::instr_u                 instr,
	input  logic [core_pkg::WORD_BITS-1:0]  rd_data_a,
	input  logic [core_pkg::WORD_BITS-1:0]  rd_data_b,
	input  logic                            flag_z,
	input  logic                            flag_s,
	input  logic                            flag_c,
	output logic [core_pkg::REG_BITS-1:0]   rd_addr_a,
	output logic [core_pkg::REG_BITS-1:0]   rd_addr_b,
	output logic                            stall,
	output logic                            branch_taken,
	output logic [core_pkg::WORD_BITS-1:0]  branch_target,
	output logic                            iss_valid,
	output logic [core_pkg::FN_BITS-1:0]    iss_fn,
	output logic [core_pkg::WORD_BITS-1:0]  iss_a,
	output logic [core_pkg::WORD_BITS-1:0]  iss_b,
	output logic [core_pkg::REG_BITS-1:0]   iss_dest,
	output logic                            iss_wen,
	output logic                            iss_flags_en
);
	import core_pkg::*;
	import isa_pkg::*;

	logic [IMM_HI_BITS-1:0] imm_hi;
	logic [WORD_BITS-1:0]   imm_full;
	logic                   use_a;
	logic                   use_b;
	logic                   use_imm;
	logic                   dec_valid;
	logic                   dec_wen;
	logic                   dec_flags;
	logic [FN_BITS-1:0]     dec_fn;
	logic [REG_BITS-1:0]    dec_dest;
	logic                   is_pfx;
	logic                   is_br;
	logic                   cond_true;
	logic                   flags_needed;
	logic                   raw_hazard;

	assign imm_full = {imm_hi, instr.alu_view.rs};	// low nibble sits in the rs field

	always_comb begin
		rd_addr_a = instr.alu_view.rd;
		rd_addr_b = instr.alu_view.rs;
		dec_fn    = instr.alu_view.fn;
		dec_dest  = instr.alu_view.rd;
		use_a     = 1'b0;
		use_b     = 1'b0;
		use_imm   = 1'b0;
		dec_valid = 1'b0;
		dec_wen   = 1'b0;
		dec_flags = 1'b0;
		is_pfx    = 1'b0;
		is_br     = 1'b0;
		case (instr.alu_view.major)
			OP_NOP: begin
				// single-register forms read and write rs
				rd_addr_a = instr.alu_view.rs;
				dec_dest  = instr.alu_view.rs;
				case (instr.alu_view.fn)
					SUB_INC, SUB_DEC: begin
						use_a     = 1'b1;
						dec_valid = 1'b1;
						dec_wen   = 1'b1;	// flags untouched
						dec_fn    = (instr.alu_view.fn == SUB_INC) ? FN_INC : FN_DEC;
					end
					SUB_UNARY: begin
						use_a     = 1'b1;
						dec_valid = 1'b1;
						dec_wen   = 1'b1;
						dec_flags = 1'b1;
						dec_fn    = instr.alu_view.rd;	// function code in bits 7:4
					end
					default: ;	// plain nop, also the retired ret/link forms
				endcase
			end
			OP_PREFIX: begin
				is_pfx    = 1'b1;
				dec_valid = 1'b1;
			end
			OP_ALU_RR: begin
				use_a     = 1'b1;
				use_b     = 1'b1;
				dec_valid = 1'b1;
				dec_wen   = 1'b1;
				dec_flags = 1'b1;
			end
			OP_ALU_RI: begin
				use_a     = 1'b1;
				use_imm   = 1'b1;
				dec_valid = 1'b1;
				dec_wen   = 1'b1;
				dec_flags = 1'b1;
			end
			OP_BRANCH: begin
				is_br     = 1'b1;
				dec_valid = 1'b1;
			end
			default: ;	// memory ops and unused majors run as nop
		endcase
	end

	always_comb begin
		flags_needed = (instr.branch_view.cond < COND_ALWAYS);
		case (instr.branch_view.cond)
			COND_Z:      cond_true = flag_z;
			COND_NZ:     cond_true = !flag_z;
			COND_S:      cond_true = flag_s;
			COND_NS:     cond_true = !flag_s;
			COND_C:      cond_true = flag_c;
			COND_NC:     cond_true = !flag_c;
			COND_ALWAYS: cond_true = 1'b1;
			default:     cond_true = 1'b0;
		endcase
	end

	// the issued instruction writes at the end of execute, write-through covers the rest
	assign raw_hazard = iss_valid && iss_wen &&
		((use_a && (rd_addr_a == iss_dest)) || (use_b && (rd_addr_b == iss_dest)));
	assign stall = raw_hazard || (is_br && flags_needed && iss_valid && iss_flags_en);

	assign branch_taken  = is_br && cond_true && !stall;
	assign branch_target = {imm_hi, instr.branch_view.target_lo};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			imm_hi       <= '0;
			iss_valid    <= 1'b0;
			iss_wen      <= 1'b0;
			iss_flags_en <= 1'b0;
		end else begin
			if (!stall && dec_valid)
				imm_hi <= is_pfx ? instr.prefix_view.imm_hi : '0;
			iss_valid    <= dec_valid && !stall;	// bubble while stalled
			iss_wen      <= dec_wen && !stall;
			iss_flags_en <= dec_flags && !stall;
		end
	end

	always_ff @(posedge CLK) begin
		iss_fn   <= dec_fn;
		iss_a    <= rd_data_a;
		iss_b    <= use_imm ? imm_full : rd_data_b;
		iss_dest <= dec_dest;
	end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  logic                            iss_valid,
	input  logic [core_pkg::FN_BITS-1:0]    iss_fn,
	input  logic [core_pkg::WORD_BITS-1:0]  iss_a,
	input  logic [core_pkg::WORD_BITS-1:0]  iss_b,
	input  logic [core_pkg::REG_BITS-1:0]   iss_dest,
	input  logic                            iss_wen,
	input  logic                            iss_flags_en,
	output logic                            flag_z,
	output logic                            flag_s,
	output logic                            flag_c,
	output logic                            wb_en,
	output logic [core_pkg::REG_BITS-1:0]   wb_addr,
	output logic [core_pkg::WORD_BITS-1:0]  wb_data
);
	import core_pkg::*;

	logic [WORD_BITS-1:0] alu_result;
	logic                 alu_carry;

	alu u_alu (
		.fn(iss_fn),
		.a(iss_a),
		.b(iss_b),
		.result(alu_result),
		.carry(alu_carry)
	);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wb_en  <= 1'b0;
			flag_z <= 1'b0;
			flag_s <= 1'b0;
			flag_c <= 1'b0;
		end else begin
			wb_en <= iss_valid && iss_wen;
			if (iss_valid && iss_flags_en) begin
				flag_z <= (alu_result == '0);
				flag_s <= alu_result[WORD_BITS-1];
				flag_c <= alu_carry;
			end
		end
	end

	// write-back register, qualified by wb_en
	always_ff @(posedge CLK) begin
		wb_addr <= iss_dest;
		wb_data <= alu_result;
	end

endmodule

`default_nettype wire

//--- design/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  logic [core_pkg::WORD_BITS-1:0]  imem_data,
	output logic [core_pkg::WORD_BITS-1:0]  imem_addr,
	output logic                            wb_en,
	output logic [core_pkg::REG_BITS-1:0]   wb_addr,
	output logic [core_pkg::WORD_BITS-1:0]  wb_data
);
	import core_pkg::*;
	import isa_pkg::*;

	instr_u                instr;
	logic                  stall;
	logic                  branch_taken;
	logic [WORD_BITS-1:0]  branch_target;
	logic [REG_BITS-1:0]   rd_addr_a;
	logic [REG_BITS-1:0]   rd_addr_b;
	logic [WORD_BITS-1:0]  rd_data_a;
	logic [WORD_BITS-1:0]  rd_data_b;
	logic                  flag_z;
	logic                  flag_s;
	logic                  flag_c;

	// issue register, decode to execute
	logic                  iss_valid;
	logic [FN_BITS-1:0]    iss_fn;
	logic [WORD_BITS-1:0]  iss_a;
	logic [WORD_BITS-1:0]  iss_b;
	logic [REG_BITS-1:0]   iss_dest;
	logic                  iss_wen;
	logic                  iss_flags_en;

	fetch_stage u_fetch (
		.CLK(CLK), .RSTb(RSTb), .imem_data(imem_data), .stall(stall),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_addr(imem_addr), .instr(instr)
	);

	decode_stage u_decode (
		.CLK(CLK), .RSTb(RSTb), .instr(instr),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.flag_z(flag_z), .flag_s(flag_s), .flag_c(flag_c),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
		.iss_valid(iss_valid), .iss_fn(iss_fn), .iss_a(iss_a), .iss_b(iss_b),
		.iss_dest(iss_dest), .iss_wen(iss_wen), .iss_flags_en(iss_flags_en)
	);

	execute_stage u_execute (
		.CLK(CLK), .RSTb(RSTb),
		.iss_valid(iss_valid), .iss_fn(iss_fn), .iss_a(iss_a), .iss_b(iss_b),
		.iss_dest(iss_dest), .iss_wen(iss_wen), .iss_flags_en(iss_flags_en),
		.flag_z(flag_z), .flag_s(flag_s), .flag_c(flag_c),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	reg_file u_regs (
		.CLK(CLK), .RSTb(RSTb),
		.wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
	);

endmodule

`default_nettype wire

//--- bench/core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module core_sva (
	input logic        CLK,
	input logic        RSTb,
	input logic        wb_en,
	input logic [3:0]  wb_addr,
	input logic [15:0] wb_data,
	input logic        stall,
	input logic        branch_taken
);

	a_wb_known: assert property (@(posedge CLK) disable iff (!RSTb)
		wb_en |-> !$isunknown({wb_addr, wb_data}))
		else $error("write-back address or data unknown while wb_en is high");

	// the bubble clears the hazard, so a second stall cycle is never needed
	a_stall_single: assert property (@(posedge CLK) disable iff (!RSTb)
		stall |=> !stall)
		else $error("stall held for more than one cycle");

	// fetch squashes the slot behind a taken branch, decode then sees a nop
	a_branch_pulse: assert property (@(posedge CLK) disable iff (!RSTb)
		branch_taken |=> !branch_taken)
		else $error("branch taken on two cycles in a row");

endmodule

bind execute_stage core_sva sva_execute (
	.CLK(CLK), .RSTb(RSTb), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
	.stall(1'b0), .branch_taken(1'b0)
);

bind decode_stage core_sva sva_decode (
	.CLK(CLK), .RSTb(RSTb), .wb_en(1'b0), .wb_addr(4'h0), .wb_data(16'h0000),
	.stall(stall), .branch_taken(branch_taken)
);

`default_nettype wire

//--- bench/ref_model.svh
// reference model of the core, runs prog[] from address 0 until pc reaches halt
// and lists the expected register writes in exp_addr / exp_data

function automatic logic [16:0] ref_alu(input logic [3:0] fn, input logic [15:0] a,
	input logic [15:0] b);
	logic [16:0] r;	// {carry, result}
	int sh;
	sh = int'(b[3:0]);
	case (fn)
		FN_MOV:  r = {1'b0, b};
		FN_ADD:  r = {1'b0, a} + {1'b0, b};
		FN_SUB:  r = {(a < b), a - b};	// borrow
		FN_AND:  r = {1'b0, a & b};
		FN_OR:   r = {1'b0, a | b};
		FN_XOR:  r = {1'b0, a ^ b};
		FN_SHL:  r = {((sh != 0) ? a[16-sh] : 1'b0), a << sh};
		FN_SHR:  r = {((sh != 0) ? a[sh-1] : 1'b0), a >> sh};
		FN_NOT:  r = {1'b0, ~a};
		FN_NEG:  r = {(a != 16'h0000), 16'h0000 - a};
		FN_INC:  r = {(a == 16'hffff), a + 16'h0001};
		FN_DEC:  r = {(a == 16'h0000), a - 16'h0001};
		default: r = {1'b0, a};
	endcase
	return r;
endfunction

function automatic void note_write(input logic [3:0] addr, input logic [15:0] data);
	exp_addr.push_back(addr);
	exp_data.push_back(data);
endfunction

function automatic int reference_run(input int halt);
	logic [15:0] r [16];
	logic        z, s, c, take;
	logic [11:0] imm;
	logic [15:0] w, opnd, val;
	logic [16:0] res;
	int          pc, steps;
	for (int i = 0; i < 16; i++)
		r[i] = 16'h0000;
	{z, s, c} = 3'b000;
	imm = 12'h000;
	pc = 0;
	steps = 0;
	exp_addr.delete();
	exp_data.delete();
	while (pc != halt && steps < 5000) begin
		w = prog[pc[7:0]];
		pc++;
		steps++;
		case (w[15:12])
			4'h0: begin
				if (w[11:8] == SUB_INC || w[11:8] == SUB_DEC) begin
					val = (w[11:8] == SUB_INC) ? r[w[3:0]] + 16'h0001 : r[w[3:0]] - 16'h0001;
					r[w[3:0]] = val;	// flags stay as they are
					note_write(w[3:0], val);
					imm = 12'h000;
				end else if (w[11:8] == SUB_UNARY) begin
					res = ref_alu(w[7:4], r[w[3:0]], 16'h0000);
					{z, s, c} = {(res[15:0] == 16'h0000), res[15], res[16]};
					r[w[3:0]] = res[15:0];
					note_write(w[3:0], res[15:0]);
					imm = 12'h000;
				end
			end
			4'h1: imm = w[11:0];
			4'h2, 4'h3: begin
				opnd = w[12] ? {imm, w[3:0]} : r[w[3:0]];	// major 3 takes the immediate
				res = ref_alu(w[11:8], r[w[7:4]], opnd);
				{z, s, c} = {(res[15:0] == 16'h0000), res[15], res[16]};
				r[w[7:4]] = res[15:0];
				note_write(w[7:4], res[15:0]);
				imm = 12'h000;
			end
			4'h4: begin
				case (w[10:8])
					3'd0: take = z;
					3'd1: take = !z;
					3'd2: take = s;
					3'd3: take = !s;
					3'd4: take = c;
					3'd5: take = !c;
					3'd6: take = 1'b1;
					default: take = 1'b0;
				endcase
				if (take)
					pc = int'({imm, w[3:0]});
				imm = 12'h000;
			end
			default: ;
		endcase
	end
	return (pc == halt) ? exp_addr.size() : -1;
endfunction

//--- bench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
	import core_pkg::*;
	import isa_pkg::*;

	logic        CLK;
	logic        RSTb;
	logic [15:0] imem_data;
	logic [15:0] imem_addr;
	logic        wb_en;
	logic [3:0]  wb_addr;
	logic [15:0] wb_data;

	logic [15:0] prog [256];
	logic [3:0]  exp_addr [$];
	logic [15:0] exp_data [$];
	logic [3:0]  pop_addr;
	logic [15:0] pop_data;
	int          ploc;
	int          halt;
	int          errors;
	int          checks;
	int          tests;
	int          failed_tests;
	int          seed;

	`include "ref_model.svh"

	core_top uut (
		.CLK(CLK), .RSTb(RSTb), .imem_data(imem_data), .imem_addr(imem_addr),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	// instruction memory, nop outside the array
	assign imem_data = (imem_addr[15:8] == 8'h00) ? prog[imem_addr[7:0]] : 16'h0000;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	// every write-back strobe against the next expected write
	always @(posedge CLK) begin
		if (RSTb && wb_en) begin
			if (exp_addr.size() == 0) begin
				$display("unexpected write-back to r%0d at %0t ns", wb_addr, $time);
				errors++;
			end else begin
				pop_addr = exp_addr.pop_front();
				pop_data = exp_data.pop_front();
				check_value("wb_addr", {28'h0, wb_addr}, {28'h0, pop_addr});
				check_value("wb_data", {16'h0, wb_data}, {16'h0, pop_data});
			end
		end
	end

	function automatic logic [15:0] enc_rr(input logic [3:0] fn, input logic [3:0] rd,
		input logic [3:0] rs);
		return {OP_ALU_RR, fn, rd, rs};
	endfunction

	function automatic logic [15:0] enc_ri(input logic [3:0] fn, input logic [3:0] rd,
		input logic [3:0] lo);
		return {OP_ALU_RI, fn, rd, lo};
	endfunction

	function automatic logic [15:0] enc_single(input logic [3:0] sub, input logic [3:0] fn,
		input logic [3:0] rs);
		return {OP_NOP, sub, fn, rs};
	endfunction

	function automatic logic [15:0] enc_br(input logic [2:0] cond, input logic [3:0] lo);
		return {OP_BRANCH, 1'b0, cond, 4'h0, lo};
	endfunction

	task automatic emit(input logic [15:0] w);
		prog[ploc] = w;
		ploc++;
	endtask

	task automatic clear_prog();
		for (int i = 0; i < 256; i++)
			prog[i] = 16'h0000;
		ploc = 0;
	endtask

	task automatic load_const(input logic [3:0] rd, input logic [15:0] val);
		emit({OP_PREFIX, val[15:4]});
		emit(enc_ri(FN_MOV, rd, val[3:0]));
	endtask

	// prefix and branch at pos, aimed at the current end of the program
	task automatic patch_branch(input int pos, input logic [2:0] cond);
		logic [15:0] t;
		t = ploc[15:0];
		prog[pos]     = {OP_PREFIX, t[15:4]};
		prog[pos + 1] = enc_br(cond, t[3:0]);
	endtask

	task automatic emit_halt();
		logic [15:0] h;
		h = ploc[15:0];
		halt = ploc;
		emit({OP_PREFIX, h[15:4]});
		emit(enc_br(COND_ALWAYS, h[3:0]));	// loops over its own prefix
	endtask

	task automatic run_program(input string name);
		int n;
		int cnt;
		int errs_before;
		errs_before = errors;
		tests++;
		@(posedge CLK);
		RSTb <= 1'b0;
		repeat (16) @(posedge CLK);
		n = reference_run(halt);
		if (n < 0) begin
			$display("reference model did not reach the halt loop in %s", name);
			errors++;
		end
		RSTb <= 1'b1;
		cnt = 0;
		while (exp_addr.size() > 0 && cnt < 3000) begin
			@(posedge CLK);
			cnt++;
		end
		if (exp_addr.size() > 0) begin
			$display("timeout in %s: %0d write-backs never arrived", name, exp_addr.size());
			errors++;
			exp_addr.delete();
			exp_data.delete();
		end
		cnt = 0;
		while (cnt < 12) begin	// quiet window, stray writes show up here
			@(posedge CLK);
			cnt++;
		end
		if (errors != errs_before)
			failed_tests++;
		$display("test %0d %s: %s, %0d writes", tests, name,
			(errors == errs_before) ? "ok" : "failed", n);
	endtask

	task automatic random_program();
		logic [31:0]  rnd;
		logic [255:0] landing;	// addresses that an earlier branch jumps to
		int pos;
		clear_prog();
		landing = '0;
		for (int i = 0; i < 48; i++) begin
			rnd = $random(seed);
			case (rnd[2:0])
				3'd0, 3'd1: emit(enc_rr({1'b0, rnd[6:4]}, {1'b0, rnd[10:8]}, {1'b0, rnd[14:12]}));
				3'd2: emit(enc_ri({1'b0, rnd[6:4]}, {1'b0, rnd[10:8]}, rnd[15:12]));
				3'd3: emit({OP_PREFIX, rnd[27:16]});
				3'd4: emit(enc_single(rnd[4] ? SUB_INC : SUB_DEC, 4'h0, {1'b0, rnd[10:8]}));
				3'd5: emit(enc_single(SUB_UNARY, rnd[4] ? FN_NOT : FN_NEG, {1'b0, rnd[10:8]}));
				3'd6: emit(16'h0000);
				default: begin
					if (landing[ploc + 1]) begin
						emit(16'h0000);	// a branch word here would run without its prefix
					end else begin
						pos = ploc + 3 + int'(rnd[9:8]);	// forward by one to four words
						landing[pos] = 1'b1;
						emit({OP_PREFIX, pos[15:4]});
						emit(enc_br(rnd[6:4], pos[3:0]));
					end
				end
			endcase
		end
		repeat (4) emit(16'h0000);
		emit_halt();
	endtask

	initial begin
		int pos;
		RSTb = 1'b0;
		seed = 32'h30ae_402a;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		clear_prog();
		halt = 0;

		// full constants through the prefix, nops keep it
		load_const(4'd1, 16'h1234);
		load_const(4'd2, 16'hbeef);
		emit({OP_PREFIX, 12'ha5c});
		emit(16'h0000);
		emit(16'h0000);
		emit(enc_ri(FN_MOV, 4'd3, 4'h3));
		emit({OP_PREFIX, 12'h00f});
		emit(enc_ri(FN_ADD, 4'd3, 4'h1));
		emit(enc_ri(FN_OR, 4'd4, 4'h7));	// prefix already used up
		load_const(4'd5, 16'hffff);
		emit_halt();
		run_program("constants");

		clear_prog();
		load_const(4'd1, 16'h00f0);
		load_const(4'd2, 16'h0f0f);
		emit(enc_rr(FN_ADD, 4'd1, 4'd2));
		emit(enc_rr(FN_SUB, 4'd2, 4'd1));
		emit(enc_rr(FN_AND, 4'd1, 4'd2));
		emit(enc_rr(FN_OR, 4'd1, 4'd2));
		emit(enc_rr(FN_XOR, 4'd2, 4'd1));
		load_const(4'd3, 16'h8001);
		emit(enc_ri(FN_SHL, 4'd3, 4'h1));
		emit(enc_ri(FN_SHR, 4'd3, 4'h4));
		emit(enc_rr(FN_MOV, 4'd4, 4'd3));
		emit(enc_single(SUB_UNARY, FN_NOT, 4'd4));
		emit(enc_single(SUB_UNARY, FN_NEG, 4'd4));
		emit(enc_single(SUB_UNARY, FN_NEG, 4'd6));
		emit(enc_ri(FN_SHL, 4'd3, 4'h0));
		emit_halt();
		run_program("alu functions");

		// inc and dec between a flag writer and the branch that tests it
		clear_prog();
		emit(enc_ri(FN_MOV, 4'd1, 4'h5));
		emit(enc_ri(FN_SUB, 4'd1, 4'h5));
		emit(enc_br(COND_Z, 4'h4));
		emit(enc_ri(FN_MOV, 4'd7, 4'h9));
		emit(enc_single(SUB_INC, 4'h0, 4'd2));
		emit(enc_single(SUB_DEC, 4'h0, 4'd3));
		emit(enc_br(COND_Z, 4'h8));
		emit(enc_ri(FN_MOV, 4'd7, 4'h3));
		emit(enc_ri(FN_MOV, 4'd5, 4'h1));
		emit(enc_single(SUB_INC, 4'h0, 4'd5));
		emit(enc_br(COND_NZ, 4'hc));
		emit(enc_ri(FN_MOV, 4'd7, 4'h4));
		emit_halt();
		run_program("inc dec flags");

		clear_prog();
		load_const(4'd1, 16'h0003);
		repeat (3) emit(enc_rr(FN_ADD, 4'd1, 4'd1));
		emit(enc_rr(FN_ADD, 4'd2, 4'd1));
		emit(enc_rr(FN_SUB, 4'd2, 4'd1));
		emit(enc_single(SUB_INC, 4'h0, 4'd2));
		emit(enc_single(SUB_INC, 4'h0, 4'd2));
		emit(enc_single(SUB_DEC, 4'h0, 4'd2));
		emit(enc_rr(FN_XOR, 4'd1, 4'd2));
		emit(enc_single(SUB_UNARY, FN_NOT, 4'd1));
		emit(enc_rr(FN_ADD, 4'd3, 4'd1));
		emit(enc_ri(FN_ADD, 4'd3, 4'h1));
		emit_halt();
		run_program("dependent chain");

		// every condition against four flag settings
		clear_prog();
		for (int c = 0; c < 8; c++) begin
			for (int s = 0; s < 4; s++) begin
				case (s)
					0: emit(enc_ri(FN_MOV, 4'd1, 4'h0));	// Z
					1: load_const(4'd1, 16'h8000);	// S
					2: begin
						emit(enc_ri(FN_MOV, 4'd1, 4'h0));
						emit(enc_ri(FN_SUB, 4'd1, 4'h1));	// S and C
					end
					default: emit(enc_ri(FN_MOV, 4'd1, 4'h1));
				endcase
				pos = ploc;
				ploc = ploc + 2;
				emit(enc_ri(FN_MOV, 4'd2, 4'(c * 4 + s)));
				patch_branch(pos, 3'(c));
			end
		end
		emit_halt();
		run_program("branch conditions");

		for (int k = 0; k < 4; k++) begin
			random_program();
			run_program("random program");
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests,
			checks, errors);
		if (errors == 0 && failed_tests == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
design/core_pkg.sv
design/isa_pkg.sv
design/alu.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/core_top.sv
bench/core_sva.sv
bench/tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
verilator --binary --timing --assert -f tb.f --top-module tb_core -o sim_core \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_core > sim.log 2>&1 || { echo "simulation exited with an error"; exit 1; }
grep -q "^RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "^RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"
